// File: include/controller_config.svh
/* Widths for the APB debug port and the cause and stall counters. */
`ifndef CONTROLLER_CONFIG_SVH
`define CONTROLLER_CONFIG_SVH

// byte address of a debug register word
`define CTRL_APB_ADDR_WIDTH 8

// debug register and APB data word
`define CTRL_APB_DATA_WIDTH 32

// cycle counters, wrap silently
`define CTRL_COUNTER_WIDTH 16

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the controller testbench with Verilator and run it.
# Exit status is zero only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=ControllerTbSim
LOG_FILE=sim.log

rm -rf "$OBJ_DIR"

verilator --binary --timing \
    -f tb.f \
    --top-module ControllerTb \
    -Mdir "$OBJ_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG_FILE"; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL, pass message not found in $LOG_FILE"
    exit 1
fi

// File: src/BackEndController.sv
/* Back-end stall/clear for the scheduler, issue,
   execution and commit stages. */
`timescale 1ns/10ps

module BackEndController (
    input  logic                     arstN,
    input  logic                     isStageStallUpper,
    output PipelineTypes::BackCtrlVec backStall,
    output PipelineTypes::BackCtrlVec backClear
);

    import PipelineTypes::*;

    always_comb begin
        backStall = '0;
        backClear = '0;

        if (!arstN) begin
            backClear = '1;
        end
        else if (isStageStallUpper) begin
            // hold the scheduler, issued ops keep draining
            backStall[StageSc] = 1'b1;
            backStall[StageIs] = 1'b1;
        end
    end

endmodule

// File: src/Controller.sv
/* Top level of the stall/flush controller, front-end and back-end
   control side by side with the debug monitor. */
`timescale 1ns/10ps
`include "controller_config.svh"

module Controller (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            cmStageFlushUpper,
    input  logic                            rnStageSendBubbleLower,
    input  logic                            rnStageFlushUpper,
    input  logic                            idStageStallUpper,
    input  logic                            ifStageSendBubbleLower,
    input  logic                            npStageSendBubbleLower,
    input  logic                            npStageSendBubbleLowerForInterrupt,
    input  logic                            isStageStallUpper,
    input  logic                            ifStageEmpty,
    input  logic                            pdStageEmpty,
    input  logic                            idStageEmpty,
    input  logic                            rnStageEmpty,
    input  logic                            activeListEmpty,
    input  logic [`CTRL_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`CTRL_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`CTRL_APB_DATA_WIDTH-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    output PipelineTypes::FrontCtrlVec       frontStall,
    output PipelineTypes::FrontCtrlVec       frontClear,
    output PipelineTypes::BackCtrlVec        backStall,
    output PipelineTypes::BackCtrlVec        backClear,
    output logic                            stallByDecodeStage,
    output logic                            wholePipelineEmpty
);

    import PipelineTypes::*;

    // winning front-end request, only the monitor needs it
    FrontCause frontCause;

    FrontEndController FrontEndController_i (
        .arstN                              (arstN),
        .cmStageFlushUpper                  (cmStageFlushUpper),
        .rnStageSendBubbleLower             (rnStageSendBubbleLower),
        .rnStageFlushUpper                  (rnStageFlushUpper),
        .idStageStallUpper                  (idStageStallUpper),
        .ifStageSendBubbleLower             (ifStageSendBubbleLower),
        .npStageSendBubbleLower             (npStageSendBubbleLower),
        .npStageSendBubbleLowerForInterrupt (npStageSendBubbleLowerForInterrupt),
        .frontStall                         (frontStall),
        .frontClear                         (frontClear),
        .stallByDecodeStage                 (stallByDecodeStage),
        .frontCause                         (frontCause)
    );

    BackEndController BackEndController_i (
        .arstN             (arstN),
        .isStageStallUpper (isStageStallUpper),
        .backStall         (backStall),
        .backClear         (backClear)
    );

    PipelineMonitor PipelineMonitor_i (
        .clk                (clk),
        .arstN              (arstN),
        .frontStall         (frontStall),
        .frontClear         (frontClear),
        .backStall          (backStall),
        .backClear          (backClear),
        .stallByDecodeStage (stallByDecodeStage),
        .frontCause         (frontCause),
        .isStageStallUpper  (isStageStallUpper),
        .ifStageEmpty       (ifStageEmpty),
        .pdStageEmpty       (pdStageEmpty),
        .idStageEmpty       (idStageEmpty),
        .rnStageEmpty       (rnStageEmpty),
        .activeListEmpty    (activeListEmpty),
        .wholePipelineEmpty (wholePipelineEmpty),
        .paddr              (paddr),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr)
    );

endmodule

// File: src/DebugTypes.sv
/* Debug register word addresses and the APB completer state enum. */
`include "controller_config.svh"

package DebugTypes;

    // cause counters sit at AddrCauseCount + 4 * cause index
    typedef enum logic [`CTRL_APB_ADDR_WIDTH-1:0] {
        AddrFrontCtrl      = 'h00,
        AddrBackCtrl       = 'h04,
        AddrStatus         = 'h08,
        AddrCounterClear   = 'h0C,
        AddrCauseCount     = 'h10,
        AddrBackStallCount = 'h30
    } DebugAddr;

    // setup phase is seen in ApbIdle, data moves in ApbAccess
    typedef enum logic {
        ApbIdle   = 1'b0,
        ApbAccess = 1'b1
    } ApbState;

endpackage

// File: src/FrontEndController.sv
/* Front-end stall and flush arbitration, fixed priority with
   lower stages first, plus the winning cause. */
`timescale 1ns/10ps

module FrontEndController (
    input  logic                      arstN,
    input  logic                      cmStageFlushUpper,
    input  logic                      rnStageSendBubbleLower,
    input  logic                      rnStageFlushUpper,
    input  logic                      idStageStallUpper,
    input  logic                      ifStageSendBubbleLower,
    input  logic                      npStageSendBubbleLower,
    input  logic                      npStageSendBubbleLowerForInterrupt,
    output PipelineTypes::FrontCtrlVec frontStall,
    output PipelineTypes::FrontCtrlVec frontClear,
    output logic                      stallByDecodeStage,
    output PipelineTypes::FrontCause  frontCause
);

    import PipelineTypes::*;

    always_comb begin
        frontStall         = '0;
        frontClear         = '0;
        stallByDecodeStage = 1'b0;
        frontCause         = CauseNone;

        if (!arstN) begin
            // latches take invalid entries, so nothing stalls
            frontClear = '1;
        end
        else if (cmStageFlushUpper) begin
            // misprediction, drop everything not yet in the active list
            frontClear[StageDs:StageIf] = '1;
            frontCause                  = CauseCmFlush;
        end
        else if (rnStageSendBubbleLower) begin
            // out of physical registers
            frontStall[StageRn:StageNp] = '1;
            // bubble to dispatch
            frontClear[StageRn]         = 1'b1;
            frontCause                  = CauseRnBubble;
        end
        else if (rnStageFlushUpper) begin
            frontClear[StageId:StageIf] = '1;
            frontCause                  = CauseRnFlush;
        end
        else if (idStageStallUpper) begin
            // micro-op split in progress; no bubble needed
            frontStall[StageId:StageNp] = '1;
            stallByDecodeStage          = 1'b1;
            frontCause                  = CauseIdStall;
        end
        else if (ifStageSendBubbleLower) begin
            // icache miss, hold the PC and send nops down
            frontStall[StageIf:StageNp] = '1;
            frontClear[StageIf:StageNp] = '1;
            frontCause                  = CauseIfBubble;
        end
        else if (npStageSendBubbleLower || npStageSendBubbleLowerForInterrupt) begin
            frontStall[StageNp] = 1'b1;
            frontClear[StageNp] = 1'b1;
            frontCause          = CauseNpBubble;
        end
    end

endmodule

// File: src/PipelineMonitor.sv
/* Whole-pipeline-empty flag, per-cause and back-stall cycle counters,
   and the APB debug register file. */
`timescale 1ns/10ps
`include "controller_config.svh"

module PipelineMonitor (
    input  logic                            clk,
    input  logic                            arstN,
    input  PipelineTypes::FrontCtrlVec       frontStall,
    input  PipelineTypes::FrontCtrlVec       frontClear,
    input  PipelineTypes::BackCtrlVec        backStall,
    input  PipelineTypes::BackCtrlVec        backClear,
    input  logic                            stallByDecodeStage,
    input  PipelineTypes::FrontCause         frontCause,
    input  logic                            isStageStallUpper,
    input  logic                            ifStageEmpty,
    input  logic                            pdStageEmpty,
    input  logic                            idStageEmpty,
    input  logic                            rnStageEmpty,
    input  logic                            activeListEmpty,
    output logic                            wholePipelineEmpty,
    input  logic [`CTRL_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`CTRL_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`CTRL_APB_DATA_WIDTH-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);

    import PipelineTypes::*;
    import DebugTypes::*;

    localparam int CauseCount = int'(CauseNpBubble) + 1;

    ApbState                          apbState;
    logic                             setupPhase;
    logic                             accessPhase;
    logic                             counterClear;
    logic [`CTRL_COUNTER_WIDTH-1:0]   causeCount [CauseCount];
    logic [`CTRL_COUNTER_WIDTH-1:0]   backStallCount;
    logic [`CTRL_APB_ADDR_WIDTH-1:0]  causeOffset;
    logic [2:0]                       causeIdx;
    logic                             causeHit;
    logic                             addrMapped;
    logic                             apbError;
    logic [`CTRL_APB_DATA_WIDTH-1:0]  readData;

    // IF fetches something valid unless NP is cleared
    assign wholePipelineEmpty = frontClear[StageNp] && ifStageEmpty && pdStageEmpty &&
                                idStageEmpty && rnStageEmpty && activeListEmpty;

    // no wait states
    assign pready = 1'b1;

    assign setupPhase   = psel && !penable;
    assign accessPhase  = (apbState == ApbAccess) && psel && penable;
    assign counterClear = accessPhase && pwrite && (paddr == AddrCounterClear);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            apbState <= ApbIdle;
        end
        else if (setupPhase) begin
            apbState <= ApbAccess;
        end
        else begin
            apbState <= ApbIdle;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < CauseCount; i++) begin
                causeCount[i] <= '0;
            end
            backStallCount <= '0;
        end
        else if (counterClear) begin
            // clear wins over this cycle's increment
            for (int i = 0; i < CauseCount; i++) begin
                causeCount[i] <= '0;
            end
            backStallCount <= '0;
        end
        else begin
            causeCount[frontCause] <= causeCount[frontCause] + 1'b1;
            if (isStageStallUpper) begin
                backStallCount <= backStallCount + 1'b1;
            end
        end
    end

    // cause counter window 0x10..0x28, word aligned
    assign causeOffset = paddr - AddrCauseCount;
    assign causeIdx    = causeOffset[4:2];
    assign causeHit    = (paddr >= AddrCauseCount) &&
                         (causeOffset < `CTRL_APB_ADDR_WIDTH'(4 * CauseCount)) &&
                         (paddr[1:0] == 2'b00);

    always_comb begin
        readData   = '0;
        addrMapped = 1'b1;
        case (paddr)
            AddrFrontCtrl: begin
                readData[5:0]  = frontClear;
                readData[13:8] = frontStall;
            end
            AddrBackCtrl: begin
                readData[3:0]  = backClear;
                readData[11:8] = backStall;
            end
            AddrStatus: begin
                readData[0]   = wholePipelineEmpty;
                readData[1]   = stallByDecodeStage;
                readData[6:4] = frontCause;
            end
            AddrCounterClear: begin
                // write-only, reads as zero
                readData = '0;
            end
            AddrBackStallCount: begin
                readData[`CTRL_COUNTER_WIDTH-1:0] = backStallCount;
            end
            default: begin
                if (causeHit) begin
                    readData[`CTRL_COUNTER_WIDTH-1:0] = causeCount[causeIdx];
                end
                else begin
                    addrMapped = 1'b0;
                end
            end
        endcase
    end

    // only the counter clear register is writable
    assign apbError = !addrMapped || (pwrite && (paddr != AddrCounterClear));

    // sampled in setup, presented through the access cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
        else if (setupPhase) begin
            prdata  <= pwrite ? '0 : readData;
            pslverr <= apbError;
        end
        else begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

endmodule

// File: src/PipelineTypes.sv
/* Stage index enums, the front-end cause enum and the
   stall/clear vector types shared by the pipeline controllers. */
package PipelineTypes;

    // bit positions in the front-end stall/clear vectors
    typedef enum logic [2:0] {
        StageNp = 3'd0,
        StageIf = 3'd1,
        StagePd = 3'd2,
        StageId = 3'd3,
        StageRn = 3'd4,
        StageDs = 3'd5
    } FrontStage;

    // bit positions in the back-end stall/clear vectors
    typedef enum logic [1:0] {
        StageSc = 2'd0,
        StageIs = 2'd1,
        StageBe = 2'd2,
        StageCm = 2'd3
    } BackStage;

    // winning front-end request, lower stages first
    typedef enum logic [2:0] {
        CauseNone     = 3'd0,
        CauseCmFlush  = 3'd1,
        CauseRnBubble = 3'd2,
        CauseRnFlush  = 3'd3,
        CauseIdStall  = 3'd4,
        CauseIfBubble = 3'd5,
        CauseNpBubble = 3'd6
    } FrontCause;

    // one control kind per stage
    typedef logic [5:0] FrontCtrlVec;
    typedef logic [3:0] BackCtrlVec;

endpackage

// File: tb.f
+incdir+include
src/PipelineTypes.sv
src/DebugTypes.sv
src/FrontEndController.sv
src/BackEndController.sv
src/PipelineMonitor.sv
src/Controller.sv
tests/ControllerTb.sv

// File: tests/ControllerTb.sv
/* Testbench for the stall/flush controller: clock, reset, random requests,
   reference model with cycle tallies, compare tasks and APB register checks. */
`timescale 1ns/10ps
`include "controller_config.svh"

module ControllerTb;

    import PipelineTypes::*;
    import DebugTypes::*;

    localparam int RandomCycles  = 2000;
    // about twice the ~2200 cycles that the tests take
    localparam int TimeoutCycles = 5000;
    localparam int CauseSlots    = 7;

    logic clk = 1'b0;
    logic arstN = 1'b0;
    logic cmStageFlushUpper, rnStageSendBubbleLower, rnStageFlushUpper, idStageStallUpper;
    logic ifStageSendBubbleLower, npStageSendBubbleLower, npStageSendBubbleLowerForInterrupt;
    logic isStageStallUpper;
    logic ifStageEmpty, pdStageEmpty, idStageEmpty, rnStageEmpty, activeListEmpty;
    logic [`CTRL_APB_ADDR_WIDTH-1:0] paddr;
    logic psel, penable, pwrite, pready, pslverr;
    logic [`CTRL_APB_DATA_WIDTH-1:0] pwdata, prdata;
    FrontCtrlVec frontStall, frontClear;
    BackCtrlVec backStall, backClear;
    logic stallByDecodeStage, wholePipelineEmpty;

    // cycle tallies of the reference model, plus snapshots taken per APB read
    int tallyCause [CauseSlots];
    int tallyBackStall;
    int snapCause [CauseSlots];
    int snapBackStall;
    logic tallyClear = 1'b0;
    logic pendingValid = 1'b0;
    logic pendingStall = 1'b0;
    FrontCause pendingCause = CauseNone;
    int cycleCount = 0;

    Controller Controller_i (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkFrontVec(input string name, input FrontCtrlVec expected,
                                 input FrontCtrlVec actual);
        if (actual !== expected) begin
            reportFailure($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkBackVec(input string name, input BackCtrlVec expected,
                                input BackCtrlVec actual);
        if (actual !== expected) begin
            reportFailure($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkWord(input string name, input logic [`CTRL_APB_DATA_WIDTH-1:0] expected,
                             input logic [`CTRL_APB_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // req bits: 6 cm flush, 5 rn bubble, 4 rn flush, 3 id stall,
    // 2 if bubble, 1 np bubble, 0 np interrupt bubble
    function automatic void refControl(input logic rstN, input logic [6:0] req,
                                       output FrontCtrlVec stall, output FrontCtrlVec clear,
                                       output logic byDecode, output FrontCause cause);
        stall    = 6'b000000;
        clear    = 6'b000000;
        byDecode = 1'b0;
        cause    = CauseNone;
        // walk from lowest priority up, the last hit wins
        if (req[1] || req[0]) cause = CauseNpBubble;
        if (req[2]) cause = CauseIfBubble;
        if (req[3]) cause = CauseIdStall;
        if (req[4]) cause = CauseRnFlush;
        if (req[5]) cause = CauseRnBubble;
        if (req[6]) cause = CauseCmFlush;
        if (!rstN) begin
            cause = CauseNone;
            clear = 6'b111111;
        end
        case (cause)
            CauseCmFlush: clear = 6'b111110;
            CauseRnBubble: begin
                stall = 6'b011111;
                clear = 6'b010000;
            end
            CauseRnFlush: clear = 6'b001110;
            CauseIdStall: begin
                stall    = 6'b001111;
                byDecode = 1'b1;
            end
            CauseIfBubble: begin
                stall = 6'b000011;
                clear = 6'b000011;
            end
            CauseNpBubble: begin
                stall = 6'b000001;
                clear = 6'b000001;
            end
            default: ;
        endcase
    endfunction

    function automatic logic oneIn(input int unsigned n);
        return ($urandom % n) == 0;
    endfunction

    function automatic logic [6:0] randomRequests();
        logic [6:0] req;
        for (int b = 0; b < 7; b++) begin
            req[b] = oneIn(4);
        end
        return req;
    endfunction

    function automatic logic [4:0] randomEmpties();
        logic [4:0] empty;
        // mostly empty so the whole-pipeline flag shows up
        for (int b = 0; b < 5; b++) begin
            empty[b] = !oneIn(4);
        end
        return empty;
    endfunction

    task automatic driveInputs(input logic [6:0] req, input logic isStall, input logic [4:0] empty);
        cmStageFlushUpper                  <= req[6];
        rnStageSendBubbleLower             <= req[5];
        rnStageFlushUpper                  <= req[4];
        idStageStallUpper                  <= req[3];
        ifStageSendBubbleLower             <= req[2];
        npStageSendBubbleLower             <= req[1];
        npStageSendBubbleLowerForInterrupt <= req[0];
        isStageStallUpper                  <= isStall;
        {ifStageEmpty, pdStageEmpty, idStageEmpty, rnStageEmpty, activeListEmpty} <= empty;
    endtask

    // setup cycle, access cycle, then back to idle
    task automatic apbTransfer(input logic [`CTRL_APB_ADDR_WIDTH-1:0] addr, input logic write,
                               input logic [`CTRL_APB_DATA_WIDTH-1:0] wdata,
                               output logic [`CTRL_APB_DATA_WIDTH-1:0] rdata, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        // counters read at this edge hold every increment before it
        snapCause     = tallyCause;
        snapBackStall = tallyBackStall;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        checkBit("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        if (write && addr == AddrCounterClear) begin
            tallyClear = 1'b1;
        end
    endtask

    task automatic readAllCounters(input string phase);
        logic [`CTRL_APB_DATA_WIDTH-1:0] data;
        logic err;
        for (int i = 0; i < CauseSlots; i++) begin
            apbTransfer(`CTRL_APB_ADDR_WIDTH'(int'(AddrCauseCount) + 4 * i), 1'b0, '0, data, err);
            checkWord($sformatf("%s cause %0d count", phase, i),
                      `CTRL_APB_DATA_WIDTH'(snapCause[i]), data);
            checkBit($sformatf("%s cause %0d pslverr", phase, i), 1'b0, err);
        end
        apbTransfer(AddrBackStallCount, 1'b0, '0, data, err);
        checkWord({phase, " back stall count"}, `CTRL_APB_DATA_WIDTH'(snapBackStall), data);
        checkBit({phase, " back stall pslverr"}, 1'b0, err);
    endtask

    // compares the combinational outputs every cycle and keeps the tallies
    initial begin
        FrontCtrlVec expStall;
        FrontCtrlVec expClear;
        logic expByDecode;
        FrontCause expCause;
        logic [6:0] req;
        forever begin
            @(negedge clk);
            if (tallyClear) begin
                // clear at this edge wins over the increment
                tallyCause     = '{default: 0};
                tallyBackStall = 0;
                tallyClear     = 1'b0;
            end
            else if (pendingValid) begin
                tallyCause[int'(pendingCause)]++;
                if (pendingStall) begin
                    tallyBackStall++;
                end
            end
            req = {cmStageFlushUpper, rnStageSendBubbleLower, rnStageFlushUpper,
                   idStageStallUpper, ifStageSendBubbleLower, npStageSendBubbleLower,
                   npStageSendBubbleLowerForInterrupt};
            refControl(arstN, req, expStall, expClear, expByDecode, expCause);
            checkFrontVec("frontStall", expStall, frontStall);
            checkFrontVec("frontClear", expClear, frontClear);
            checkBit("stallByDecodeStage", expByDecode, stallByDecodeStage);
            checkBackVec("backStall", (arstN && isStageStallUpper) ? 4'b0011 : 4'b0000,
                         backStall);
            checkBackVec("backClear", arstN ? 4'b0000 : 4'b1111, backClear);
            checkBit("wholePipelineEmpty", expClear[0] && ifStageEmpty && pdStageEmpty &&
                     idStageEmpty && rnStageEmpty && activeListEmpty, wholePipelineEmpty);
            pendingValid = arstN;
            pendingCause = expCause;
            pendingStall = isStageStallUpper;
        end
    end

    initial begin
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        reportFailure("timeout, the tests did not finish within the cycle limit");
    end

    initial begin
        logic [`CTRL_APB_DATA_WIDTH-1:0] data;
        logic [`CTRL_APB_DATA_WIDTH-1:0] expWord;
        logic err;
        logic [6:0] held;
        logic [4:0] heldEmpty;
        logic heldStall;
        FrontCtrlVec expStall;
        FrontCtrlVec expClear;
        logic expByDecode;
        FrontCause expCause;

        void'($urandom(54));
        tallyCause = '{default: 0};
        tallyBackStall = 0;
        {cmStageFlushUpper, rnStageSendBubbleLower, rnStageFlushUpper, idStageStallUpper} = '0;
        {ifStageSendBubbleLower, npStageSendBubbleLower} = '0;
        npStageSendBubbleLowerForInterrupt = 1'b0;
        isStageStallUpper = 1'b0;
        {ifStageEmpty, pdStageEmpty, idStageEmpty, rnStageEmpty, activeListEmpty} = '0;
        {paddr, psel, penable, pwrite, pwdata} = '0;

        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkWord("reset prdata", '0, prdata);
        checkBit("reset pslverr", 1'b0, pslverr);
        readAllCounters("reset");

        // random requests, the compare process checks every cycle
        repeat (RandomCycles) begin
            @(posedge clk);
            driveInputs(randomRequests(), oneIn(4), randomEmpties());
        end
        @(posedge clk);
        driveInputs('0, 1'b0, '0);
        readAllCounters("random");

        // one held pattern per cause, lower priority requests mixed in
        for (int i = 7; i >= 0; i--) begin
            held = (i < 7) ? (7'(1 << i) | (randomRequests() & 7'((1 << i) - 1))) : 7'd0;
            heldEmpty = randomEmpties();
            heldStall = oneIn(2);
            @(posedge clk);
            driveInputs(held, heldStall, heldEmpty);
            refControl(1'b1, held, expStall, expClear, expByDecode, expCause);
            apbTransfer(AddrFrontCtrl, 1'b0, '0, data, err);
            expWord = '0;
            expWord[5:0] = expClear;
            expWord[13:8] = expStall;
            checkWord($sformatf("front snapshot %0d", i), expWord, data);
            apbTransfer(AddrStatus, 1'b0, '0, data, err);
            expWord = '0;
            expWord[0] = expClear[0] && (&heldEmpty);
            expWord[1] = expByDecode;
            expWord[6:4] = expCause;
            checkWord($sformatf("status snapshot %0d", i), expWord, data);
            apbTransfer(AddrBackCtrl, 1'b0, '0, data, err);
            // issue stall holds SC and IS, nothing is cleared
            expWord = '0;
            expWord[11:8] = heldStall ? 4'b0011 : 4'b0000;
            checkWord($sformatf("back snapshot %0d", i), expWord, data);
        end
        @(posedge clk);
        driveInputs('0, 1'b0, '0);
        readAllCounters("held");

        apbTransfer(AddrCounterClear, 1'b1, 32'h0000_00A5, data, err);
        checkBit("counter clear pslverr", 1'b0, err);
        readAllCounters("cleared");

        apbTransfer(8'h34, 1'b0, '0, data, err);
        checkBit("unmapped read pslverr", 1'b1, err);
        apbTransfer(8'h2C, 1'b0, '0, data, err);
        checkBit("past cause window pslverr", 1'b1, err);
        apbTransfer(8'h11, 1'b0, '0, data, err);
        checkBit("misaligned read pslverr", 1'b1, err);
        apbTransfer(AddrStatus, 1'b1, 32'hFFFF_FFFF, data, err);
        checkBit("status write pslverr", 1'b1, err);
        readAllCounters("errors");

        $display("sim passed");
        $finish;
    end

endmodule
